//--- design/rob_pkg.sv
// Reorder buffer shared definitions

package rob_pkg;

  // Buffer geometry
  localparam int ROB_SIZE_BITS = 4;
  localparam int ROB_DEPTH     = 2 ** ROB_SIZE_BITS;

  // Result buses and commit buses come in the same number
  localparam int NUM_BUSES = 2;

  // Data values and instruction addresses
  typedef logic [31:0] word_t;

  // Architectural register number
  typedef logic [4:0] reg_addr_t;

  // Slot index into the circular buffer
  typedef logic [ROB_SIZE_BITS-1:0] rob_index_t;

  // Occupancy needs one extra bit to reach ROB_DEPTH
  typedef logic [ROB_SIZE_BITS:0] rob_count_t;

  // Commit bus number
  typedef logic bus_sel_t;

  // Life of one buffer entry
  typedef enum logic [1:0] {
    WAITING   = 2'd0,
    COMPLETED = 2'd1,
    IGNORE    = 2'd2
  } record_status_e;

endpackage

//--- design/cdb_arbiter.sv
// Commit bus arbiter

`timescale 1ns/10ps

module cdb_arbiter import rob_pkg::*; (
  input  logic                 cs,
  input  logic                 i_reset,
  input  logic                 i_request,
  input  logic [NUM_BUSES-1:0] i_bus_busy,
  output logic                 o_grant,
  output bus_sel_t             o_bus
);

  logic [NUM_BUSES-1:0] bus_free;
  bus_sel_t             last_used;

  assign bus_free = ~i_bus_busy;

  // Grant needs a request and at least one idle bus
  assign o_grant = i_request && (bus_free != '0);

  always_comb begin
    if (bus_free == 2'b11) begin
      // Both idle, take the one not used last
      o_bus = ~last_used;
    end else if (bus_free[1]) begin
      o_bus = 1'b1;
    end else begin
      o_bus = 1'b0;
    end
  end

  // Remember the last granted bus for round robin
  always_ff @(posedge cs) begin
    if (i_reset) begin
      // First tie goes to bus 0
      last_used <= 1'b1;
    end else if (o_grant) begin
      last_used <= o_bus;
    end
  end

endmodule

//--- design/reorder_buffer.sv
// Reorder buffer with in-order commit

`timescale 1ns/10ps

module reorder_buffer import rob_pkg::*; (
  input  logic                 cs,
  input  logic                 i_reset,
  // Issue slot 0
  input  logic                 i_issue0_valid,
  input  word_t                i_issue0_pc,
  input  reg_addr_t            i_issue0_rd,
  input  logic                 i_issue0_writes,
  input  logic                 i_issue0_jumps,
  input  logic                 i_issue0_tag,
  // Issue slot 1
  input  logic                 i_issue1_valid,
  input  word_t                i_issue1_pc,
  input  reg_addr_t            i_issue1_rd,
  input  logic                 i_issue1_writes,
  input  logic                 i_issue1_jumps,
  input  logic                 i_issue1_tag,
  // Result buses
  input  logic                 i_res0_valid,
  input  word_t                i_res0_pc,
  input  word_t                i_res0_result,
  input  word_t                i_res0_target,
  input  logic                 i_res1_valid,
  input  word_t                i_res1_pc,
  input  word_t                i_res1_result,
  input  word_t                i_res1_target,
  input  logic [NUM_BUSES-1:0] i_bus_busy,
  output logic                 o_full,
  output logic                 o_jmp_write,
  output word_t                o_jmp_address,
  // Commit port
  output logic                 o_commit_valid,
  output bus_sel_t             o_commit_bus,
  output reg_addr_t            o_commit_rd,
  output word_t                o_commit_result,
  output logic                 o_commit_writes
);

  // Entry fields
  record_status_e status [ROB_DEPTH];
  word_t          pc     [ROB_DEPTH];
  word_t          result [ROB_DEPTH];
  word_t          target [ROB_DEPTH];
  reg_addr_t      rd     [ROB_DEPTH];
  logic           writes [ROB_DEPTH];
  logic           jumps  [ROB_DEPTH];
  logic           tag    [ROB_DEPTH];

  rob_index_t     head;
  rob_index_t     tail;
  rob_index_t     tail_next;
  rob_count_t     count;

  logic [ROB_DEPTH-1:0] hit0;
  logic [ROB_DEPTH-1:0] hit1;

  logic           request;
  logic           grant;
  bus_sel_t       grant_bus;
  logic           pop;
  logic           jump_commit;
  logic           mispredict;
  logic           accept0;
  logic           accept1;
  logic [1:0]     num_in;

  cdb_arbiter u_arbiter (
    .cs        (cs),
    .i_reset   (i_reset),
    .i_request (request),
    .i_bus_busy(i_bus_busy),
    .o_grant   (grant),
    .o_bus     (grant_bus)
  );

  // Result match against every waiting entry
  always_comb begin
    for (int i = 0; i < ROB_DEPTH; i++) begin
      hit0[i] = i_res0_valid && status[i] == WAITING && pc[i] == i_res0_pc;
      hit1[i] = i_res1_valid && status[i] == WAITING && pc[i] == i_res1_pc;
    end
  end

  assign request = (count != '0) && status[head] == COMPLETED;

  // Skipped entries leave one per cycle with no commit
  assign pop = (count != '0) && (grant || status[head] == IGNORE);

  assign jump_commit = grant && jumps[head];
  assign mispredict  = jump_commit && target[head] != word_t'(pc[head] + 32'd4);

  // Less than two free slots
  assign o_full = count > rob_count_t'(ROB_DEPTH - 2);

  // Issue is dropped on the redirect edge
  assign accept0   = i_issue0_valid && !o_full && !mispredict;
  assign accept1   = accept0 && i_issue1_valid;
  assign num_in    = {1'b0, accept0} + {1'b0, accept1};
  assign tail_next = tail + rob_index_t'(1);

  assign o_commit_valid  = grant;
  assign o_commit_bus    = grant_bus;
  assign o_commit_rd     = rd[head];
  assign o_commit_result = result[head];
  assign o_commit_writes = grant && writes[head];

  // Status, tags, pointers and redirect strobe
  always_ff @(posedge cs) begin
    if (i_reset) begin
      for (int i = 0; i < ROB_DEPTH; i++) begin
        status[i] <= IGNORE;
        tag[i]    <= 1'b0;
      end
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      o_jmp_write <= 1'b0;
    end else begin
      for (int i = 0; i < ROB_DEPTH; i++) begin
        if (hit0[i] || hit1[i]) begin
          status[i] <= COMPLETED;
        end
      end

      if (mispredict) begin
        // Drop everything issued under the wrong path
        for (int i = 0; i < ROB_DEPTH; i++) begin
          if (tag[i]) begin
            status[i] <= IGNORE;
            tag[i]    <= 1'b0;
          end
        end
      end else if (jump_commit) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
          tag[i] <= 1'b0;
        end
      end

      if (pop) begin
        status[head] <= IGNORE;
      end

      // New entries start waiting
      if (accept0) begin
        status[tail] <= WAITING;
        tag[tail]    <= i_issue0_tag;
      end
      if (accept1) begin
        status[tail_next] <= WAITING;
        tag[tail_next]    <= i_issue1_tag;
      end

      head        <= head + rob_index_t'(pop);
      tail        <= tail + rob_index_t'(num_in);
      count       <= count + rob_count_t'(num_in) - rob_count_t'(pop);
      o_jmp_write <= mispredict;
    end
  end

  // Entry payload and redirect address
  always_ff @(posedge cs) begin
    for (int i = 0; i < ROB_DEPTH; i++) begin
      if (hit0[i]) begin
        result[i] <= i_res0_result;
        if (jumps[i]) begin
          target[i] <= i_res0_target;
        end
      end
      // Bus 1 wins when both carry the same pc
      if (hit1[i]) begin
        result[i] <= i_res1_result;
        if (jumps[i]) begin
          target[i] <= i_res1_target;
        end
      end
    end

    if (accept0) begin
      pc[tail]     <= i_issue0_pc;
      rd[tail]     <= i_issue0_rd;
      writes[tail] <= i_issue0_writes;
      jumps[tail]  <= i_issue0_jumps;
    end
    if (accept1) begin
      pc[tail_next]     <= i_issue1_pc;
      rd[tail_next]     <= i_issue1_rd;
      writes[tail_next] <= i_issue1_writes;
      jumps[tail_next]  <= i_issue1_jumps;
    end

    if (mispredict) begin
      o_jmp_address <= target[head];
    end
  end

endmodule

//--- design/arch_regfile.sv
// Architectural register file

`timescale 1ns/10ps

module arch_regfile import rob_pkg::*; (
  input  logic      cs,
  input  logic      i_reset,
  input  logic      i_write,
  input  reg_addr_t i_write_addr,
  input  word_t     i_write_data,
  input  reg_addr_t i_rd_addr,
  output word_t     o_rd_data
);

  localparam int NUM_REGS = 32;

  word_t regs [NUM_REGS];

  // Commit write port
  always_ff @(posedge cs) begin
    if (i_reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_write && i_write_addr != '0) begin
      // x0 is never written
      regs[i_write_addr] <= i_write_data;
    end
  end

  // Asynchronous read, x0 hardwired to zero
  always_comb begin
    if (i_rd_addr == '0) begin
      o_rd_data = '0;
    end else begin
      o_rd_data = regs[i_rd_addr];
    end
  end

endmodule

//--- design/rob_subsystem.sv
// Retirement subsystem top level

`timescale 1ns/10ps

module rob_subsystem import rob_pkg::*; (
  input  logic                 cs,
  input  logic                 i_reset,
  // Issue slots
  input  logic                 i_issue0_valid,
  input  word_t                i_issue0_pc,
  input  reg_addr_t            i_issue0_rd,
  input  logic                 i_issue0_writes,
  input  logic                 i_issue0_jumps,
  input  logic                 i_issue0_tag,
  input  logic                 i_issue1_valid,
  input  word_t                i_issue1_pc,
  input  reg_addr_t            i_issue1_rd,
  input  logic                 i_issue1_writes,
  input  logic                 i_issue1_jumps,
  input  logic                 i_issue1_tag,
  // Result buses
  input  logic                 i_res0_valid,
  input  word_t                i_res0_pc,
  input  word_t                i_res0_result,
  input  word_t                i_res0_target,
  input  logic                 i_res1_valid,
  input  word_t                i_res1_pc,
  input  word_t                i_res1_result,
  input  word_t                i_res1_target,
  input  logic [NUM_BUSES-1:0] i_bus_busy,
  input  reg_addr_t            i_rd_addr,
  output logic                 o_full,
  output logic                 o_jmp_write,
  output word_t                o_jmp_address,
  output logic                 o_commit_valid,
  output bus_sel_t             o_commit_bus,
  output reg_addr_t            o_commit_rd,
  output word_t                o_commit_result,
  output word_t                o_rd_data
);

  // Already qualified by the commit grant
  logic commit_writes;

  reorder_buffer u_rob (
    .cs             (cs),
    .i_reset        (i_reset),
    .i_issue0_valid (i_issue0_valid),
    .i_issue0_pc    (i_issue0_pc),
    .i_issue0_rd    (i_issue0_rd),
    .i_issue0_writes(i_issue0_writes),
    .i_issue0_jumps (i_issue0_jumps),
    .i_issue0_tag   (i_issue0_tag),
    .i_issue1_valid (i_issue1_valid),
    .i_issue1_pc    (i_issue1_pc),
    .i_issue1_rd    (i_issue1_rd),
    .i_issue1_writes(i_issue1_writes),
    .i_issue1_jumps (i_issue1_jumps),
    .i_issue1_tag   (i_issue1_tag),
    .i_res0_valid   (i_res0_valid),
    .i_res0_pc      (i_res0_pc),
    .i_res0_result  (i_res0_result),
    .i_res0_target  (i_res0_target),
    .i_res1_valid   (i_res1_valid),
    .i_res1_pc      (i_res1_pc),
    .i_res1_result  (i_res1_result),
    .i_res1_target  (i_res1_target),
    .i_bus_busy     (i_bus_busy),
    .o_full         (o_full),
    .o_jmp_write    (o_jmp_write),
    .o_jmp_address  (o_jmp_address),
    .o_commit_valid (o_commit_valid),
    .o_commit_bus   (o_commit_bus),
    .o_commit_rd    (o_commit_rd),
    .o_commit_result(o_commit_result),
    .o_commit_writes(commit_writes)
  );

  arch_regfile u_regfile (
    .cs          (cs),
    .i_reset     (i_reset),
    .i_write     (commit_writes),
    .i_write_addr(o_commit_rd),
    .i_write_data(o_commit_result),
    .i_rd_addr   (i_rd_addr),
    .o_rd_data   (o_rd_data)
  );

endmodule

//--- testbench/rob_tb_assert.sv
// Reorder buffer assertions

`timescale 1ns/10ps

module rob_tb_assert import rob_pkg::*; (
  input logic       cs,
  input logic       i_reset,
  input logic       i_jmp_write,
  input logic       i_full,
  input logic       i_issue0_valid,
  input logic       i_issue1_valid,
  input rob_count_t i_count
);

  // Redirect is a single cycle pulse
  jmp_pulse: assert property (@(posedge cs) disable iff (i_reset)
    i_jmp_write |=> !i_jmp_write)
    else $error("o_jmp_write held longer than one cycle");

  // Occupancy cannot grow while full
  no_issue_when_full: assert property (@(posedge cs) disable iff (i_reset)
    i_full |=> i_count <= $past(i_count))
    else $error("Issue accepted while full");

  count_bound: assert property (@(posedge cs) disable iff (i_reset)
    i_count <= rob_count_t'(ROB_DEPTH))
    else $error("Occupancy above buffer depth");

  // Slot 1 never alone
  slot_order: assert property (@(posedge cs) disable iff (i_reset)
    i_issue1_valid |-> i_issue0_valid)
    else $error("Issue slot 1 valid without slot 0");

endmodule

bind reorder_buffer rob_tb_assert u_assert (
  .cs            (cs),
  .i_reset       (i_reset),
  .i_jmp_write   (o_jmp_write),
  .i_full        (o_full),
  .i_issue0_valid(i_issue0_valid),
  .i_issue1_valid(i_issue1_valid),
  .i_count       (count)
);

//--- testbench/rob_tb.sv
// Retirement subsystem testbench

`timescale 1ns/10ps

module rob_tb import rob_pkg::*; ();

  // One instruction of a scenario
  typedef struct packed {
    logic [3:0] row;
    word_t      pc;
    reg_addr_t  rd;
    word_t      val;
    logic       wr;
    logic       jmp;
    word_t      tgt;
    logic       tag;
  } step_t;

  localparam int NUM_ROWS     = 4;
  localparam int NUM_STEPS    = 18;
  localparam int QUIET_CYCLES = 16;
  localparam int LIMIT_CYCLES = (NUM_ROWS + 1) * 60 + 200;

  // row, pc, rd, value, writes, jumps, target, tag
  localparam step_t STEPS [NUM_STEPS] = '{
    '{4'd0, 32'h100, 5'd1,  32'h11,   1'b1, 1'b0, 32'h0,   1'b0},
    '{4'd0, 32'h104, 5'd2,  32'h22,   1'b1, 1'b0, 32'h0,   1'b0},
    '{4'd0, 32'h108, 5'd3,  32'h33,   1'b1, 1'b0, 32'h0,   1'b0},
    '{4'd0, 32'h10c, 5'd4,  32'h44,   1'b1, 1'b0, 32'h0,   1'b0},
    '{4'd0, 32'h110, 5'd5,  32'h55,   1'b1, 1'b0, 32'h0,   1'b0},
    '{4'd0, 32'h114, 5'd6,  32'h66,   1'b1, 1'b0, 32'h0,   1'b0},
    // Jump predicted right, tagged ones retire
    '{4'd1, 32'h200, 5'd7,  32'h77,   1'b1, 1'b0, 32'h0,   1'b0},
    '{4'd1, 32'h204, 5'd8,  32'h208,  1'b1, 1'b1, 32'h208, 1'b0},
    '{4'd1, 32'h208, 5'd9,  32'h99,   1'b1, 1'b0, 32'h0,   1'b1},
    '{4'd1, 32'h20c, 5'd10, 32'haa,   1'b1, 1'b0, 32'h0,   1'b1},
    // Mispredicted jump squashes the tagged tail
    '{4'd2, 32'h300, 5'd11, 32'hbb,   1'b1, 1'b0, 32'h0,   1'b0},
    '{4'd2, 32'h304, 5'd12, 32'h308,  1'b1, 1'b1, 32'h400, 1'b0},
    '{4'd2, 32'h308, 5'd13, 32'hcc,   1'b1, 1'b0, 32'h0,   1'b1},
    '{4'd2, 32'h30c, 5'd14, 32'hdd,   1'b1, 1'b0, 32'h0,   1'b1},
    '{4'd2, 32'h310, 5'd1,  32'hee,   1'b1, 1'b0, 32'h0,   1'b1},
    // x0 and non-writing instructions
    '{4'd3, 32'h500, 5'd0,  32'hdead, 1'b1, 1'b0, 32'h0,   1'b0},
    '{4'd3, 32'h504, 5'd2,  32'hbeef, 1'b0, 1'b0, 32'h0,   1'b0},
    '{4'd3, 32'h508, 5'd3,  32'hf00d, 1'b1, 1'b0, 32'h0,   1'b0}
  };

  logic                 cs;
  logic                 i_reset;
  logic                 i_issue0_valid, i_issue0_writes, i_issue0_jumps, i_issue0_tag;
  word_t                i_issue0_pc;
  reg_addr_t            i_issue0_rd;
  logic                 i_issue1_valid, i_issue1_writes, i_issue1_jumps, i_issue1_tag;
  word_t                i_issue1_pc;
  reg_addr_t            i_issue1_rd;
  logic                 i_res0_valid, i_res1_valid;
  word_t                i_res0_pc, i_res0_result, i_res0_target;
  word_t                i_res1_pc, i_res1_result, i_res1_target;
  logic [NUM_BUSES-1:0] i_bus_busy;
  reg_addr_t            i_rd_addr;
  logic                 o_full, o_jmp_write, o_commit_valid;
  word_t                o_jmp_address, o_commit_result, o_rd_data;
  bus_sel_t             o_commit_bus;
  reg_addr_t            o_commit_rd;

  // Program under test
  word_t     ins_pc  [ROB_DEPTH];
  reg_addr_t ins_rd  [ROB_DEPTH];
  word_t     ins_val [ROB_DEPTH];
  word_t     ins_tgt [ROB_DEPTH];
  logic      ins_wr  [ROB_DEPTH];
  logic      ins_jmp [ROB_DEPTH];
  logic      ins_tag [ROB_DEPTH];
  int        ins_n;

  // Reference model state
  int        exp_idx [$];
  word_t     model_regs [32];
  bus_sel_t  last_bus;
  int        value_errors;
  int        other_errors;

  rob_subsystem uut (.*);

  always #4 cs = ~cs;

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic load_row(input int r);
    ins_n = 0;
    for (int s = 0; s < NUM_STEPS; s++) begin
      if (STEPS[s].row == 4'(r)) begin
        ins_pc[ins_n]  = STEPS[s].pc;
        ins_rd[ins_n]  = STEPS[s].rd;
        ins_val[ins_n] = STEPS[s].val;
        ins_tgt[ins_n] = STEPS[s].tgt;
        ins_wr[ins_n]  = STEPS[s].wr;
        ins_jmp[ins_n] = STEPS[s].jmp;
        ins_tag[ins_n] = STEPS[s].tag;
        ins_n++;
      end
    end
  endtask

  // Fifteen plain writers, enough to fill the buffer
  task automatic load_fill();
    ins_n = ROB_DEPTH - 1;
    for (int i = 0; i < ins_n; i++) begin
      ins_pc[i]  = word_t'(32'h1000 + 4 * i);
      ins_rd[i]  = reg_addr_t'(16 + i);
      ins_val[i] = $urandom;
      ins_tgt[i] = '0;
      ins_wr[i]  = 1'b1;
      ins_jmp[i] = 1'b0;
      ins_tag[i] = 1'b0;
    end
  endtask

  task automatic set_slot(input int slot, input int i);
    if (slot == 0) begin
      i_issue0_valid  = 1'b1;
      i_issue0_pc     = ins_pc[i];
      i_issue0_rd     = ins_rd[i];
      i_issue0_writes = ins_wr[i];
      i_issue0_jumps  = ins_jmp[i];
      i_issue0_tag    = ins_tag[i];
    end else begin
      i_issue1_valid  = 1'b1;
      i_issue1_pc     = ins_pc[i];
      i_issue1_rd     = ins_rd[i];
      i_issue1_writes = ins_wr[i];
      i_issue1_jumps  = ins_jmp[i];
      i_issue1_tag    = ins_tag[i];
    end
  endtask

  // Issue in pairs, checking o_full against the occupancy before each group
  task automatic issue_program(input bit single_first);
    int k;
    int issued;
    int size;
    k = 0;
    issued = 0;
    while (k < ins_n) begin
      size = (k == 0 && single_first) || (ins_n - k == 1) ? 1 : 2;
      @(posedge cs);
      #1;
      i_issue1_valid = 1'b0;
      set_slot(0, k);
      if (size == 2) begin
        set_slot(1, k + 1);
      end
      @(negedge cs);
      check_bit("o_full", o_full, (ROB_DEPTH - issued) < 2);
      issued += size;
      k += size;
    end
    @(posedge cs);
    #1;
    i_issue0_valid = 1'b0;
    i_issue1_valid = 1'b0;
    @(negedge cs);
    check_bit("o_full", o_full, (ROB_DEPTH - issued) < 2);
  endtask

  // Program order minus tagged work behind a wrong jump
  task automatic build_expect();
    bit squash;
    squash = 1'b0;
    exp_idx.delete();
    for (int i = 0; i < ins_n; i++) begin
      if (!(squash && ins_tag[i])) begin
        exp_idx.push_back(i);
        if (ins_jmp[i] && ins_tgt[i] != word_t'(ins_pc[i] + 32'd4)) begin
          squash = 1'b1;
        end
      end
    end
  endtask

  task automatic drive_results();
    int          order [$];
    int          tmp;
    int unsigned j;
    int unsigned rnd;
    int          k;
    for (int i = 0; i < ins_n; i++) begin
      order.push_back(i);
    end
    for (int i = ins_n - 1; i > 0; i--) begin
      j = $urandom % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    while (order.size() > 0) begin
      @(posedge cs);
      #1;
      rnd = $urandom;
      k = order.pop_front();
      i_res0_valid  = 1'b1;
      i_res0_pc     = ins_pc[k];
      i_res0_result = ins_val[k];
      i_res0_target = ins_tgt[k];
      i_res1_valid  = 1'b0;
      if (order.size() > 0 && rnd[0]) begin
        k = order.pop_front();
        i_res1_valid  = 1'b1;
        i_res1_pc     = ins_pc[k];
        i_res1_result = ins_val[k];
        i_res1_target = ins_tgt[k];
      end
    end
    @(posedge cs);
    #1;
    i_res0_valid = 1'b0;
    i_res1_valid = 1'b0;
  endtask

  task automatic collect_commits();
    int          quiet;
    int          k;
    int unsigned rnd;
    logic        jmp_due;
    word_t       jmp_addr;
    bus_sel_t    exp_bus;
    quiet = 0;
    jmp_due = 1'b0;
    jmp_addr = '0;
    while (quiet < QUIET_CYCLES) begin
      @(posedge cs);
      #1;
      rnd = $urandom;
      i_bus_busy = rnd[1:0];
      @(negedge cs);
      check_bit("o_jmp_write", o_jmp_write, jmp_due);
      if (jmp_due) begin
        check_word("o_jmp_address", o_jmp_address, jmp_addr);
      end
      jmp_due = 1'b0;
      if (i_bus_busy == 2'b11) begin
        check_bit("o_commit_valid", o_commit_valid, 1'b0);
      end
      if (o_commit_valid === 1'b1) begin
        if (exp_idx.size() == 0) begin
          $display("Commit of rd %0d at %0t with nothing left to retire", o_commit_rd, $time);
          other_errors++;
        end else begin
          k = exp_idx.pop_front();
          check_reg("o_commit_rd", o_commit_rd, ins_rd[k]);
          check_word("o_commit_result", o_commit_result, ins_val[k]);
          // Free bus only, alternating when both are free
          if (i_bus_busy == 2'b00) begin
            exp_bus = ~last_bus;
          end else begin
            exp_bus = !i_bus_busy[1];
          end
          check_bit("o_commit_bus", o_commit_bus, exp_bus);
          last_bus = exp_bus;
          if (ins_wr[k] && ins_rd[k] != '0) begin
            model_regs[ins_rd[k]] = ins_val[k];
          end
          if (ins_jmp[k] && ins_tgt[k] != word_t'(ins_pc[k] + 32'd4)) begin
            jmp_due = 1'b1;
            jmp_addr = ins_tgt[k];
          end
        end
      end
      if (exp_idx.size() == 0 && !jmp_due) begin
        quiet++;
      end
    end
  endtask

  task automatic run_program();
    build_expect();
    fork
      drive_results();
      collect_commits();
    join
  endtask

  task automatic check_regs();
    for (int i = 0; i < ins_n; i++) begin
      @(posedge cs);
      #1;
      i_rd_addr = ins_rd[i];
      @(negedge cs);
      check_word("o_rd_data", o_rd_data, model_regs[ins_rd[i]]);
    end
  endtask

  initial begin
    repeat (LIMIT_CYCLES) @(posedge cs);
    $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    void'($urandom(67));
    cs = 1'b0;
    i_reset = 1'b1;
    {i_issue0_valid, i_issue0_writes, i_issue0_jumps, i_issue0_tag} = '0;
    {i_issue1_valid, i_issue1_writes, i_issue1_jumps, i_issue1_tag} = '0;
    i_issue0_pc = '0;
    i_issue0_rd = '0;
    i_issue1_pc = '0;
    i_issue1_rd = '0;
    {i_res0_valid, i_res0_pc, i_res0_result, i_res0_target} = '0;
    {i_res1_valid, i_res1_pc, i_res1_result, i_res1_target} = '0;
    i_bus_busy = '0;
    i_rd_addr = '0;
    value_errors = 0;
    other_errors = 0;
    last_bus = 1'b1;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (8) @(posedge cs);
    #1;
    i_reset = 1'b0;

    // Fill to full, then drain
    load_fill();
    issue_program(1'b0);
    run_program();
    check_bit("o_full", o_full, 1'b0);
    check_regs();

    for (int r = 0; r < NUM_ROWS; r++) begin
      load_row(r);
      issue_program(1'b1);
      run_program();
      check_regs();
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/rob_pkg.sv
design/cdb_arbiter.sv
design/reorder_buffer.sv
design/arch_regfile.sv
design/rob_subsystem.sv
testbench/rob_tb_assert.sv
testbench/rob_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f filelist.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
